//--- src/emon_defs.svh
/*
 shared widths, monitor count and register map
 of the link traffic monitor
*/
`ifndef EMON_DEFS_SVH
`define EMON_DEFS_SVH

// memory interface and counter width
`define EMON_DW 32

// number of event monitors, up to 8 fit the config word
`define EMON_MONS 6

// memory interface address width
`define EMON_AW 20

// register map, consecutive words
// config word first, then rx monitors, then tx monitors
`define EMON_REG_CFG    20'hf036c
`define EMON_REG_RXMON0 20'hf0370
`define EMON_REG_RXMON1 20'hf0374
`define EMON_REG_RXMON2 20'hf0378
`define EMON_REG_TXMON0 20'hf037c
`define EMON_REG_TXMON1 20'hf0380
`define EMON_REG_TXMON2 20'hf0384

// byte step between two monitor registers
`define EMON_REG_STEP 4

`endif

//--- src/emon_reg_pkg.sv
/*
 register-side types: event select field and
 the two views of the configuration word
*/
`default_nettype none

`include "emon_defs.svh"

package emon_reg_pkg;

   // one select field per monitor
   localparam int EMON_SEL_W = 4;

   // select fields packed into one config word
   localparam int EMON_SEL_FIELDS = `EMON_DW / EMON_SEL_W;

   // index into the event vector
   typedef logic [EMON_SEL_W-1:0] emon_sel_t;

   // config word
   // word is the bus view, mon_sel the per-counter view
   // monitor i takes mon_sel[i], i.e. bits 4i+3..4i
   typedef union packed
   {
      logic [`EMON_DW-1:0]             word;
      emon_sel_t [EMON_SEL_FIELDS-1:0] mon_sel;
   } emon_cfg_u;

endpackage

`default_nettype wire

//--- src/emon_event_pkg.sv
/*
 event-side types: event vector and the
 named positions of its entries
*/
`default_nettype none

package emon_event_pkg;

   // entries in the event vector
   localparam int EMON_EV_W = 16;

   // one bit per countable event
   typedef logic [EMON_EV_W-1:0] emon_vec_t;

   // position of each event in the vector
   // matches the 4-bit select encoding
   typedef enum logic [$clog2(EMON_EV_W)-1:0]
   {
      ev_off             = 4'd0,   // constant zero, counter holds
      ev_clk             = 4'd1,   // constant one, counts cycles
      // receive path fifos
      ev_erx_rd_access   = 4'd2,
      ev_erx_rd_wait     = 4'd3,
      ev_erx_wr_access   = 4'd4,
      ev_erx_wr_wait     = 4'd5,
      ev_erx_wb_access   = 4'd6,
      ev_erx_wb_wait     = 4'd7,
      // transmit path fifos
      ev_etx_rd_access   = 4'd8,
      ev_etx_rd_wait     = 4'd9,
      ev_etx_wr_access   = 4'd10,
      ev_etx_wr_wait     = 4'd11,
      ev_etx_wb_access   = 4'd12,
      ev_etx_wb_wait     = 4'd13,
      // unused, tied low
      ev_spare0          = 4'd14,
      ev_spare1          = 4'd15
   } emon_event_e;

endpackage

`default_nettype wire

//--- src/emon_counter.sv
/*
 single event monitor: loadable down counter
 with event select and zero flag
*/
`timescale 1ns/100ps
`default_nettype none

`include "emon_defs.svh"

module emon_counter
   import emon_reg_pkg::*, emon_event_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  emon_vec_t           event_vec,
   input  emon_sel_t           sel,
   input  logic                load,
   input  logic [`EMON_DW-1:0] load_data,
   output logic [`EMON_DW-1:0] count,
   output logic                zero_flag
);

   // selected event for this monitor
   logic event_hit;

   assign event_hit = event_vec[sel];

   // software load wins over a decrement in the same cycle
   // count sticks at zero
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else if (load)
      begin
         count <= load_data;
      end
      else if (event_hit && !zero_flag)
      begin
         count <= count - 1'b1;
      end
   end

   // same-cycle flag, straight from the count
   assign zero_flag = (count == '0);

endmodule

`default_nettype wire

//--- src/emon_regfile.sv
/*
 register file: address decode, write strobes,
 config register and registered readback mux
*/
`timescale 1ns/100ps
`default_nettype none

`include "emon_defs.svh"

module emon_regfile
   import emon_reg_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  reset,
   // memory interface
   input  logic                                  mi_access,
   input  logic                                  mi_write,
   input  logic [`EMON_AW-1:0]                   mi_addr,
   input  logic [`EMON_DW-1:0]                   mi_data_in,
   output logic [`EMON_DW-1:0]                   mi_data_out,
   output logic                                  mi_data_sel,
   // counter side
   input  logic [`EMON_MONS-1:0][`EMON_DW-1:0]   mon_count,
   output emon_cfg_u                             cfg,
   output logic [`EMON_MONS-1:0]                 mon_write,
   output logic [`EMON_DW-1:0]                   write_data
);

   // address match per register
   logic                  cfg_match;
   logic [`EMON_MONS-1:0] mon_match;
   logic                  any_match;

   // qualified strobes
   logic                  wr_access;
   logic                  rd_access;
   logic                  cfg_write;

   // combinational readback value
   logic [`EMON_DW-1:0]   rd_mux;

   assign wr_access = mi_access & mi_write;
   assign rd_access = mi_access & ~mi_write;

   // decode
   assign cfg_match = (mi_addr == `EMON_REG_CFG);

   // monitor registers follow rxmon0 one word apart
   always_comb
   begin
      for (int i = 0; i < `EMON_MONS; i++)
      begin
         mon_match[i] = (mi_addr == `EMON_AW'(`EMON_REG_RXMON0 + `EMON_REG_STEP * i));
      end
   end

   assign any_match = cfg_match | (|mon_match);

   // write strobes
   assign cfg_write  = wr_access & cfg_match;
   assign mon_write  = {`EMON_MONS{wr_access}} & mon_match;
   assign write_data = mi_data_in;

   // config register, written whole through the raw view
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cfg.word <= '0;
      end
      else if (cfg_write)
      begin
         cfg.word <= mi_data_in;
      end
   end

   // or of masked sources, at most one match is set
   // no match gives zero
   always_comb
   begin
      rd_mux = {`EMON_DW{cfg_match}} & cfg.word;
      for (int i = 0; i < `EMON_MONS; i++)
      begin
         rd_mux = rd_mux | ({`EMON_DW{mon_match[i]}} & mon_count[i]);
      end
   end

   // readback one cycle after the request
   // held until the next read
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mi_data_out <= '0;
         mi_data_sel <= 1'b0;
      end
      else if (rd_access)
      begin
         mi_data_out <= rd_mux;
         mi_data_sel <= any_match;
      end
   end

endmodule

`default_nettype wire

//--- src/emon.sv
/*
 link traffic monitor top: event vector,
 register file and the monitor counters
*/
`timescale 1ns/100ps
`default_nettype none

`include "emon_defs.svh"

module emon
   import emon_reg_pkg::*, emon_event_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   // memory interface
   input  logic                  mi_access,
   input  logic                  mi_write,
   input  logic [`EMON_AW-1:0]   mi_addr,
   input  logic [`EMON_DW-1:0]   mi_data_in,
   output logic [`EMON_DW-1:0]   mi_data_out,
   output logic                  mi_data_sel,   // readback mux select
   // receive path strobes
   input  logic                  erx_rdfifo_access,
   input  logic                  erx_rdfifo_wait,
   input  logic                  erx_wrfifo_access,
   input  logic                  erx_wrfifo_wait,
   input  logic                  erx_wbfifo_access,
   input  logic                  erx_wbfifo_wait,
   // transmit path strobes
   input  logic                  etx_rdfifo_access,
   input  logic                  etx_rdfifo_wait,
   input  logic                  etx_wrfifo_access,
   input  logic                  etx_wrfifo_wait,
   input  logic                  etx_wbfifo_access,
   input  logic                  etx_wbfifo_wait,
   // one flag per monitor
   output logic [`EMON_MONS-1:0] emon_zero_flag
);

   emon_vec_t                             event_vec;
   emon_cfg_u                             cfg;
   logic [`EMON_MONS-1:0]                 mon_write;
   logic [`EMON_DW-1:0]                   write_data;
   logic [`EMON_MONS-1:0][`EMON_DW-1:0]   mon_count;

   // event vector, positions from the event enum
   always_comb
   begin
      event_vec                   = '0;
      event_vec[ev_off]           = 1'b0;
      event_vec[ev_clk]           = 1'b1;
      event_vec[ev_erx_rd_access] = erx_rdfifo_access;
      event_vec[ev_erx_rd_wait]   = erx_rdfifo_wait;
      event_vec[ev_erx_wr_access] = erx_wrfifo_access;
      event_vec[ev_erx_wr_wait]   = erx_wrfifo_wait;
      event_vec[ev_erx_wb_access] = erx_wbfifo_access;
      event_vec[ev_erx_wb_wait]   = erx_wbfifo_wait;
      event_vec[ev_etx_rd_access] = etx_rdfifo_access;
      event_vec[ev_etx_rd_wait]   = etx_rdfifo_wait;
      event_vec[ev_etx_wr_access] = etx_wrfifo_access;
      event_vec[ev_etx_wr_wait]   = etx_wrfifo_wait;
      event_vec[ev_etx_wb_access] = etx_wbfifo_access;
      event_vec[ev_etx_wb_wait]   = etx_wbfifo_wait;
      // spares read as zero
      event_vec[ev_spare0]        = 1'b0;
      event_vec[ev_spare1]        = 1'b0;
   end

   emon_regfile u_regfile
   (
      .clk         (clk),
      .reset       (reset),
      .mi_access   (mi_access),
      .mi_write    (mi_write),
      .mi_addr     (mi_addr),
      .mi_data_in  (mi_data_in),
      .mi_data_out (mi_data_out),
      .mi_data_sel (mi_data_sel),
      .mon_count   (mon_count),
      .cfg         (cfg),
      .mon_write   (mon_write),
      .write_data  (write_data)
   );

   // monitor i reads select field i of the config word
   for (genvar i = 0; i < `EMON_MONS; i++)
   begin : gen_mon
      emon_counter u_counter
      (
         .clk       (clk),
         .reset     (reset),
         .event_vec (event_vec),
         .sel       (cfg.mon_sel[i]),
         .load      (mon_write[i]),
         .load_data (write_data),
         .count     (mon_count[i]),
         .zero_flag (emon_zero_flag[i])
      );
   end

endmodule

`default_nettype wire

//--- dv/emon_tb.sv
/*
 link traffic monitor testbench
 stimulus file replay, result checks and watchdog
*/
`timescale 1ns/100ps
`default_nettype none

`include "emon_defs.svh"

module emon_tb;

   localparam INPUT_FILE = "dv/emon_input.txt";

   logic                  clk;
   logic                  reset;
   logic                  mi_access;
   logic                  mi_write;
   logic [`EMON_AW-1:0]   mi_addr;
   logic [`EMON_DW-1:0]   mi_data_in;
   logic [`EMON_DW-1:0]   mi_data_out;
   logic                  mi_data_sel;
   logic [`EMON_MONS-1:0] emon_zero_flag;
   // bit 0 erx_rdfifo_access up to bit 11 etx_wbfifo_wait
   logic [11:0]           strobes;

   // watchdog limit from a first pass over the file
   int                    budget_cycles;
   bit                    budget_ready;

   emon uut
   (
      .clk               (clk),
      .reset             (reset),
      .mi_access         (mi_access),
      .mi_write          (mi_write),
      .mi_addr           (mi_addr),
      .mi_data_in        (mi_data_in),
      .mi_data_out       (mi_data_out),
      .mi_data_sel       (mi_data_sel),
      .erx_rdfifo_access (strobes[0]),
      .erx_rdfifo_wait   (strobes[1]),
      .erx_wrfifo_access (strobes[2]),
      .erx_wrfifo_wait   (strobes[3]),
      .erx_wbfifo_access (strobes[4]),
      .erx_wbfifo_wait   (strobes[5]),
      .etx_rdfifo_access (strobes[6]),
      .etx_rdfifo_wait   (strobes[7]),
      .etx_wrfifo_access (strobes[8]),
      .etx_wrfifo_wait   (strobes[9]),
      .etx_wbfifo_access (strobes[10]),
      .etx_wbfifo_wait   (strobes[11]),
      .emon_zero_flag    (emon_zero_flag)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
   endtask

   // first pass sums hold cycles plus 10 per line
   task automatic count_budget();
      int               fd;
      int               n;
      int               cycles;
      logic [7:0]       op;
      logic [11:0]      pattern;
      logic [8*160-1:0] rest;
      budget_cycles = 20;
      fd = $fopen(INPUT_FILE, "r");
      if (fd == 0)
         stop_on_error("cannot open the stimulus file dv/emon_input.txt");
      while ($fscanf(fd, " %c", op) == 1)
      begin
         if (op == "E")
         begin
            n = $fscanf(fd, "%h %d", pattern, cycles);
            assert (n == 2)
               else stop_on_error("malformed E line in the stimulus file");
            budget_cycles += cycles;
         end
         // rest of the line, comments included
         n = $fgets(rest, fd);
         budget_cycles += 10;
      end
      $fclose(fd);
      budget_ready = 1'b1;
   endtask

   // all tasks start and end on a falling edge
   task automatic write_reg(input logic [`EMON_AW-1:0] addr, input logic [`EMON_DW-1:0] data);
      mi_access  = 1'b1;
      mi_write   = 1'b1;
      mi_addr    = addr;
      mi_data_in = data;
      @(negedge clk);
      mi_access  = 1'b0;
      mi_write   = 1'b0;
   endtask

   // readback registered on the edge in between
   task automatic read_check(input logic [`EMON_AW-1:0] addr, input logic exp_sel,
                             input logic [`EMON_DW-1:0] exp_data);
      mi_access = 1'b1;
      mi_write  = 1'b0;
      mi_addr   = addr;
      @(negedge clk);
      mi_access = 1'b0;
      assert (mi_data_sel === exp_sel)
         else stop_on_error($sformatf("error: mi_data_sel at %h is %h, expected %h",
                                      addr, mi_data_sel, exp_sel));
      assert (mi_data_out === exp_data)
         else stop_on_error($sformatf("error: mi_data_out at %h is %h, expected %h",
                                      addr, mi_data_out, exp_data));
   endtask

   // strobes high for exactly cycles rising edges
   task automatic hold_events(input logic [11:0] pattern, input int cycles);
      strobes = pattern;
      repeat (cycles) @(negedge clk);
      strobes = '0;
   endtask

   initial
   begin
      int                    fd;
      int                    n;
      int                    cycles;
      logic [7:0]            op;
      logic [`EMON_AW-1:0]   addr;
      logic [`EMON_DW-1:0]   data;
      logic                  exp_sel;
      logic [11:0]           pattern;
      logic [`EMON_MONS-1:0] exp_flags;
      logic [8*160-1:0]      rest;
      reset        = 1'b1;
      mi_access    = 1'b0;
      mi_write     = 1'b0;
      mi_addr      = '0;
      mi_data_in   = '0;
      strobes      = '0;
      budget_ready = 1'b0;
      count_budget();
      // reset over 4 rising edges
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      fd = $fopen(INPUT_FILE, "r");
      // one operation per line
      while ($fscanf(fd, " %c", op) == 1)
      begin
         case (op)
            "W":
            begin
               n = $fscanf(fd, "%h %h", addr, data);
               assert (n == 2)
                  else stop_on_error("malformed W line in the stimulus file");
               write_reg(addr, data);
            end
            "R":
            begin
               n = $fscanf(fd, "%h %h %h", addr, exp_sel, data);
               assert (n == 3)
                  else stop_on_error("malformed R line in the stimulus file");
               read_check(addr, exp_sel, data);
            end
            "E":
            begin
               n = $fscanf(fd, "%h %d", pattern, cycles);
               assert (n == 2)
                  else stop_on_error("malformed E line in the stimulus file");
               hold_events(pattern, cycles);
            end
            "Z":
            begin
               n = $fscanf(fd, "%h", exp_flags);
               assert (n == 1)
                  else stop_on_error("malformed Z line in the stimulus file");
               // flags sampled mid-cycle, stable after the rising edge
               assert (emon_zero_flag === exp_flags)
                  else stop_on_error($sformatf("error: emon_zero_flag is %h, expected %h",
                                               emon_zero_flag, exp_flags));
            end
            "#":
               n = $fgets(rest, fd);
            default:
               stop_on_error($sformatf("unknown opcode %c in the stimulus file", op));
         endcase
      end
      $fclose(fd);
      $display("=== PASS ===");
      $finish;
   end

   // watchdog
   initial
   begin
      wait (budget_ready);
      repeat (budget_cycles) @(posedge clk);
      $display("timeout: the stimulus did not finish within %0d cycles", budget_cycles);
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/emon_reg_pkg.sv
src/emon_event_pkg.sv
src/emon_counter.sv
src/emon_regfile.sv
src/emon.sv
dv/emon_tb.sv

//--- Bender.yml
package:
  name: emon

sources:
  - include_dirs:
      - src
    files:
      - src/emon_reg_pkg.sv
      - src/emon_event_pkg.sv
      - src/emon_counter.sv
      - src/emon_regfile.sv
      - src/emon.sv

  - target: test
    include_dirs:
      - src
    files:
      - dv/emon_tb.sv

//--- dv/emon_input.txt
# W addr data | R addr exp_sel exp_data | E strobes cycles | Z exp_zero_flags
# hex except the E cycle count; strobe bit 0 erx_rdfifo_access .. bit 11 etx_wbfifo_wait
Z 3f
R f036c 1 00000000
R f0370 1 00000000
R f0374 1 00000000
R f0378 1 00000000
R f037c 1 00000000
R f0380 1 00000000
R f0384 1 00000000
# sel: mon0 erx rd acc, mon1 erx rd wait, mon2 off, mon3 etx rd acc, mon4 etx wb wait, mon5 clk
W f036c a51d8032
R f036c 1 a51d8032
W f0370 00000064
W f0374 00000032
W f0378 12345678
W f037c 000000c8
W f0380 00000010
Z 20
R f0370 1 00000064
R f0374 1 00000032
R f0378 1 12345678
R f037c 1 000000c8
R f0380 1 00000010
E 001 5
R f0370 1 0000005f
R f0374 1 00000032
E 002 3
E 004 4
E 040 2
E fff 3
E 800 20
Z 30
R f0370 1 0000005c
R f0374 1 0000002c
R f0378 1 12345678
R f037c 1 000000c3
R f0380 1 00000000
# mon5 counts every cycle, loaded below the cycle count
W f0384 00000005
R f0384 1 00000005
E 000 3
Z 10
E 000 4
Z 30
R f0384 1 00000000
R f0000 0 00000000
R f0388 0 00000000
# load while ev_clk is high, no decrement on the load edge
W f0384 00000020
R f0384 1 00000020
Z 10
